// ==== source/idct_settings.svh ====
`ifndef IDCT_SETTINGS_SVH
`define IDCT_SETTINGS_SVH

// SRAM geometry in words
`define IDCT_SRAM_AW 18
`define IDCT_SRAM_DW 16
`define IDCT_PRE_STRIDE 320
`define IDCT_POST_STRIDE 160

// Fixed point
`define IDCT_C_FRAC 12
`define IDCT_PASS1_SHIFT 8
`define IDCT_PASS2_SHIFT 16

// Block buffers and pending output addresses
`define IDCT_BUF_DEPTH 64
`define IDCT_QUEUE_DEPTH 4

`endif

// ==== source/idct_pkg.sv ====
`include "idct_settings.svh"

package idct_pkg;

	typedef logic [`IDCT_SRAM_AW-1:0] sram_addr_t;
	typedef logic [`IDCT_SRAM_DW-1:0] sram_data_t;

	// Sign bit on top of the fraction
	typedef logic signed [`IDCT_C_FRAC:0] cos_t;
	typedef logic signed [15:0] coeff_t;
	typedef logic signed [31:0] acc_t;
	typedef logic [7:0] pixel_t;

	// Row in [5:3], column in [2:0]
	typedef logic [5:0] elem_idx_t;

	typedef enum logic [1:0] {FETCH_IDLE, FETCH_READ, FETCH_DRAIN} fetch_state_t;
	typedef enum logic [1:0] {STORE_IDLE, STORE_READ, STORE_WRITE, STORE_DONE} store_state_t;
	typedef enum logic [1:0] {ENG_IDLE, ENG_PASS1, ENG_WAIT_OUT, ENG_PASS2} engine_state_t;

endpackage

// ==== source/coeff_rom.sv ====
module coeff_rom import idct_pkg::*; (
	input  logic [2:0] row_i,
	input  logic [2:0] col_i,
	output cos_t       cos_o
);

	cos_t row_vals [8];

	// C[i][j] = round(4096 * c(i) * cos((2j+1) * i * pi / 16))
	always_comb begin
		case (row_i)
			3'd0: row_vals = '{1448, 1448, 1448, 1448, 1448, 1448, 1448, 1448};
			3'd1: row_vals = '{2009, 1703, 1138, 400, -400, -1138, -1703, -2009};
			3'd2: row_vals = '{1892, 784, -784, -1892, -1892, -784, 784, 1892};
			3'd3: row_vals = '{1703, -400, -2009, -1138, 1138, 2009, 400, -1703};
			3'd4: row_vals = '{1448, -1448, -1448, 1448, 1448, -1448, -1448, 1448};
			3'd5: row_vals = '{1138, -2009, 400, 1703, -1703, -400, 2009, -1138};
			3'd6: row_vals = '{784, -1892, 1892, -784, -784, 1892, -1892, 784};
			default: row_vals = '{400, -1138, 1703, -2009, 2009, -1703, 1138, -400};
		endcase
		cos_o = row_vals[col_i];
	end

endmodule

// ==== source/sram_arbiter.sv ====
module sram_arbiter import idct_pkg::*; (
	input  logic       Clock,
	input  logic       Resetn,
	input  logic       req_a_i,
	input  logic       we_a_i,
	input  sram_addr_t addr_a_i,
	input  sram_data_t wdata_a_i,
	output logic       gnt_a_o,
	output sram_data_t rdata_a_o,
	input  logic       req_b_i,
	input  logic       we_b_i,
	input  sram_addr_t addr_b_i,
	input  sram_data_t wdata_b_i,
	output logic       gnt_b_o,
	output sram_data_t rdata_b_o,
	output sram_addr_t sram_addr_o,
	output sram_data_t sram_wdata_o,
	output logic       sram_we_n_o,
	input  sram_data_t sram_rdata_i
);

	logic prefer_b_q;
	// Read owner per stage of the port register and the SRAM
	logic [1:0] own_a_q;
	logic [1:0] own_b_q;

	assign gnt_a_o = req_a_i & (~req_b_i | ~prefer_b_q);
	assign gnt_b_o = req_b_i & (~req_a_i | prefer_b_q);

	assign rdata_a_o = own_a_q[1] ? sram_rdata_i : '0;
	assign rdata_b_o = own_b_q[1] ? sram_rdata_i : '0;

	always_ff @(posedge Clock) begin
		sram_addr_o <= gnt_b_o ? addr_b_i : addr_a_i;
		sram_wdata_o <= gnt_b_o ? wdata_b_i : wdata_a_i;
	end

	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			prefer_b_q <= 1'b0;
			sram_we_n_o <= 1'b1;
			own_a_q <= '0;
			own_b_q <= '0;
		end else begin
			if (gnt_a_o)
				prefer_b_q <= 1'b1;
			else if (gnt_b_o)
				prefer_b_q <= 1'b0;
			sram_we_n_o <= ~((gnt_a_o & we_a_i) | (gnt_b_o & we_b_i));
			own_a_q <= {own_a_q[0], gnt_a_o & ~we_a_i};
			own_b_q <= {own_b_q[0], gnt_b_o & ~we_b_i};
		end
	end

	// The loser of a tie wins the next cycle if it still asks
	assert property (@(posedge Clock) disable iff (!Resetn)
		(req_a_i && req_b_i) |=>
		($past(gnt_b_o) ? (!req_a_i || gnt_a_o) : (!req_b_i || gnt_b_o)));

endmodule

// ==== source/block_fetch.sv ====
`include "idct_settings.svh"

module block_fetch import idct_pkg::*; (
	input  logic       Clock,
	input  logic       Resetn,
	input  logic       start_i,
	input  sram_addr_t block_addr_i,
	input  logic       in_free_i,
	output logic       req_o,
	output sram_addr_t addr_o,
	input  logic       gnt_i,
	input  sram_data_t rdata_i,
	output logic       fill_we_o,
	output logic       fill_sel_o,
	output elem_idx_t  fill_idx_o,
	output coeff_t     fill_data_o,
	output logic       fill_done_o,
	output logic       busy_o
);

	fetch_state_t state_q;
	sram_addr_t base_q;
	sram_addr_t row_off_q;
	elem_idx_t idx_q;
	logic accept;
	logic xfer;
	logic fill_sel_q;
	// Tag of the read on the SRAM port, then of the word coming back
	logic tag_vld_q;
	elem_idx_t tag_idx_q;
	logic ret_vld_q;
	elem_idx_t ret_idx_q;

	assign accept = (state_q == FETCH_IDLE) && start_i && in_free_i;
	assign req_o = (state_q == FETCH_READ);
	assign xfer = req_o & gnt_i;
	assign addr_o = base_q + row_off_q + sram_addr_t'(idx_q[2:0]);
	assign busy_o = (state_q != FETCH_IDLE);

	assign fill_we_o = ret_vld_q;
	assign fill_sel_o = fill_sel_q;
	assign fill_idx_o = ret_idx_q;
	assign fill_data_o = coeff_t'(rdata_i);
	assign fill_done_o = ret_vld_q && (ret_idx_q == 6'd63);

	always_ff @(posedge Clock) begin
		if (accept)
			base_q <= block_addr_i;
		if (xfer)
			tag_idx_q <= idx_q;
		ret_idx_q <= tag_idx_q;
	end

	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			state_q <= FETCH_IDLE;
			idx_q <= '0;
			row_off_q <= '0;
			tag_vld_q <= 1'b0;
			ret_vld_q <= 1'b0;
			fill_sel_q <= 1'b0;
		end else begin
			tag_vld_q <= xfer;
			ret_vld_q <= tag_vld_q;
			case (state_q)
				FETCH_IDLE: begin
					idx_q <= '0;
					row_off_q <= '0;
					if (accept)
						state_q <= FETCH_READ;
				end
				FETCH_READ: begin
					if (xfer) begin
						idx_q <= idx_q + 6'd1;
						if (idx_q[2:0] == 3'd7)
							row_off_q <= row_off_q + sram_addr_t'(`IDCT_PRE_STRIDE);
						if (idx_q == 6'd63)
							state_q <= FETCH_DRAIN;
					end
				end
				FETCH_DRAIN: begin
					if (fill_done_o) begin
						fill_sel_q <= ~fill_sel_q;
						state_q <= FETCH_IDLE;
					end
				end
				default: state_q <= FETCH_IDLE;
			endcase
		end
	end

endmodule

// ==== source/idct_engine.sv ====
`include "idct_settings.svh"

module idct_engine import idct_pkg::*; (
	input  logic      Clock,
	input  logic      Resetn,
	input  logic      fill_we_i,
	input  logic      fill_sel_i,
	input  elem_idx_t fill_idx_i,
	input  coeff_t    fill_data_i,
	input  logic      fill_done_i,
	output logic      in_free_o,
	output logic      out_valid_o,
	input  elem_idx_t rd_idx_i,
	output pixel_t    rd_pixel_o,
	input  logic      out_taken_i
);

	// 256 issue steps plus 3 to drain the pipeline
	localparam logic [8:0] STEP_LAST = 9'd258;

	engine_state_t state_q;
	logic [8:0] step_q;
	logic [1:0] in_full_q;
	logic rd_sel_q;
	logic out_full_q;

	coeff_t in_buf [2][`IDCT_BUF_DEPTH];
	acc_t t_buf [`IDCT_BUF_DEPTH];
	pixel_t px_buf [`IDCT_BUF_DEPTH];

	logic pass2;
	logic issue;
	logic [1:0] kp;
	logic [2:0] row;
	logic [2:0] col;
	elem_idx_t ridx0;
	elem_idx_t ridx1;
	cos_t cos0;
	cos_t cos1;

	logic [2:0] vld_q;
	logic [7:0] tag_q [3];
	acc_t op0_q;
	acc_t op1_q;
	cos_t cs0_q;
	cos_t cs1_q;
	acc_t prod0_q;
	acc_t prod1_q;
	acc_t acc_q;
	acc_t t_val;
	acc_t s_val;

	assign pass2 = (state_q == ENG_PASS2);
	assign issue = (state_q == ENG_PASS1 || pass2) && !step_q[8];
	assign kp = step_q[1:0];
	assign row = step_q[7:5];
	assign col = step_q[4:2];

	// Pass one walks S' along a row, pass two walks T down a column
	assign ridx0 = pass2 ? {kp, 1'b0, col} : {row, kp, 1'b0};
	assign ridx1 = pass2 ? {kp, 1'b1, col} : {row, kp, 1'b1};

	coeff_rom rom0 (
		.row_i ({kp, 1'b0}),
		.col_i (pass2 ? row : col),
		.cos_o (cos0)
	);

	coeff_rom rom1 (
		.row_i ({kp, 1'b1}),
		.col_i (pass2 ? row : col),
		.cos_o (cos1)
	);

	assign t_val = acc_q >>> `IDCT_PASS1_SHIFT;
	assign s_val = acc_q >>> `IDCT_PASS2_SHIFT;
	assign in_free_o = ~&in_full_q;
	assign rd_pixel_o = px_buf[rd_idx_i];

	always_ff @(posedge Clock) begin
		if (fill_we_i)
			in_buf[fill_sel_i][fill_idx_i] <= fill_data_i;
		op0_q <= pass2 ? t_buf[ridx0] : acc_t'(in_buf[rd_sel_q][ridx0]);
		op1_q <= pass2 ? t_buf[ridx1] : acc_t'(in_buf[rd_sel_q][ridx1]);
		cs0_q <= cos0;
		cs1_q <= cos1;
		tag_q[0] <= step_q[7:0];
		prod0_q <= op0_q * cs0_q;
		prod1_q <= op1_q * cs1_q;
		tag_q[1] <= tag_q[0];
		if (vld_q[1])
			acc_q <= ((tag_q[1][1:0] == 2'd0) ? acc_t'(0) : acc_q) + prod0_q + prod1_q;
		tag_q[2] <= tag_q[1];
		if (vld_q[2] && tag_q[2][1:0] == 2'd3) begin
			if (!pass2)
				t_buf[tag_q[2][7:2]] <= t_val;
			else if (s_val < 0)
				px_buf[tag_q[2][7:2]] <= 8'd0;
			else if (s_val > 255)
				px_buf[tag_q[2][7:2]] <= 8'd255;
			else
				px_buf[tag_q[2][7:2]] <= s_val[7:0];
		end
	end

	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			state_q <= ENG_IDLE;
			step_q <= '0;
			in_full_q <= '0;
			rd_sel_q <= 1'b0;
			out_full_q <= 1'b0;
			out_valid_o <= 1'b0;
			vld_q <= '0;
		end else begin
			out_valid_o <= 1'b0;
			vld_q <= {vld_q[1:0], issue};
			if (fill_done_i)
				in_full_q[fill_sel_i] <= 1'b1;
			if (out_taken_i)
				out_full_q <= 1'b0;
			case (state_q)
				ENG_IDLE: begin
					step_q <= '0;
					if (in_full_q[rd_sel_q])
						state_q <= ENG_PASS1;
				end
				ENG_PASS1: begin
					step_q <= step_q + 9'd1;
					if (step_q == STEP_LAST) begin
						step_q <= '0;
						in_full_q[rd_sel_q] <= 1'b0;
						rd_sel_q <= ~rd_sel_q;
						state_q <= out_full_q ? ENG_WAIT_OUT : ENG_PASS2;
					end
				end
				ENG_WAIT_OUT: begin
					if (!out_full_q)
						state_q <= ENG_PASS2;
				end
				ENG_PASS2: begin
					step_q <= step_q + 9'd1;
					if (step_q == STEP_LAST) begin
						step_q <= '0;
						out_full_q <= 1'b1;
						out_valid_o <= 1'b1;
						state_q <= ENG_IDLE;
					end
				end
				default: state_q <= ENG_IDLE;
			endcase
		end
	end

	// Fetcher and engine stay on opposite input buffers
	assert property (@(posedge Clock) disable iff (!Resetn)
		(fill_we_i && state_q == ENG_PASS1) |-> (fill_sel_i != rd_sel_q));

endmodule

// ==== source/block_store.sv ====
`include "idct_settings.svh"

module block_store import idct_pkg::*; (
	input  logic       Clock,
	input  logic       Resetn,
	input  logic       cmd_push_i,
	input  sram_addr_t cmd_addr_i,
	input  logic       out_valid_i,
	output elem_idx_t  rd_idx_o,
	input  pixel_t     rd_pixel_i,
	output logic       out_taken_o,
	output logic       req_o,
	output sram_addr_t addr_o,
	output sram_data_t wdata_o,
	input  logic       gnt_i,
	output logic       done_o
);

	localparam int PTR_W = $clog2(`IDCT_QUEUE_DEPTH);

	store_state_t state_q;
	sram_addr_t queue_q [`IDCT_QUEUE_DEPTH];
	logic [PTR_W-1:0] wr_ptr_q;
	logic [PTR_W-1:0] rd_ptr_q;
	// Row in [4:2], word within the row in [1:0]
	logic [4:0] word_q;
	sram_addr_t row_off_q;
	pixel_t hi_q;

	assign rd_idx_o = {word_q, state_q == STORE_WRITE};
	assign req_o = (state_q == STORE_WRITE);
	assign addr_o = queue_q[rd_ptr_q] + row_off_q + sram_addr_t'(word_q[1:0]);
	// Even column in the upper byte
	assign wdata_o = {hi_q, rd_pixel_i};
	assign out_taken_o = (state_q == STORE_DONE);

	always_ff @(posedge Clock) begin
		if (cmd_push_i)
			queue_q[wr_ptr_q] <= cmd_addr_i;
		if (state_q == STORE_READ)
			hi_q <= rd_pixel_i;
	end

	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			state_q <= STORE_IDLE;
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			word_q <= '0;
			row_off_q <= '0;
			done_o <= 1'b0;
		end else begin
			done_o <= (state_q == STORE_DONE);
			if (cmd_push_i)
				wr_ptr_q <= wr_ptr_q + 1'b1;
			case (state_q)
				STORE_IDLE: begin
					word_q <= '0;
					row_off_q <= '0;
					if (out_valid_i)
						state_q <= STORE_READ;
				end
				STORE_READ: state_q <= STORE_WRITE;
				STORE_WRITE: begin
					if (gnt_i) begin
						word_q <= word_q + 5'd1;
						if (word_q[1:0] == 2'd3)
							row_off_q <= row_off_q + sram_addr_t'(`IDCT_POST_STRIDE);
						state_q <= (word_q == 5'd31) ? STORE_DONE : STORE_READ;
					end
				end
				STORE_DONE: begin
					rd_ptr_q <= rd_ptr_q + 1'b1;
					state_q <= STORE_IDLE;
				end
				default: state_q <= STORE_IDLE;
			endcase
		end
	end

endmodule

// ==== source/idct_top.sv ====
module idct_top import idct_pkg::*; (
	input  logic       Clock,
	input  logic       Resetn,
	input  logic       start_i,
	input  sram_addr_t block_addr_i,
	input  sram_addr_t out_addr_i,
	output logic       ready_o,
	output logic       done_o,
	output sram_addr_t sram_addr_o,
	output sram_data_t sram_wdata_o,
	output logic       sram_we_n_o,
	input  sram_data_t sram_rdata_i
);

	logic fetch_req;
	sram_addr_t fetch_addr;
	logic fetch_gnt;
	sram_data_t fetch_rdata;
	logic fetch_busy;
	logic fill_we;
	logic fill_sel;
	elem_idx_t fill_idx;
	coeff_t fill_data;
	logic fill_done;
	logic in_free;
	logic out_valid;
	elem_idx_t rd_idx;
	pixel_t rd_pixel;
	logic out_taken;
	logic store_req;
	sram_addr_t store_addr;
	sram_data_t store_wdata;
	logic store_gnt;
	logic cmd_push;

	assign ready_o = in_free & ~fetch_busy;
	assign cmd_push = start_i & ready_o;

	block_fetch fetch0 (
		.Clock        (Clock),
		.Resetn       (Resetn),
		.start_i      (start_i),
		.block_addr_i (block_addr_i),
		.in_free_i    (in_free),
		.req_o        (fetch_req),
		.addr_o       (fetch_addr),
		.gnt_i        (fetch_gnt),
		.rdata_i      (fetch_rdata),
		.fill_we_o    (fill_we),
		.fill_sel_o   (fill_sel),
		.fill_idx_o   (fill_idx),
		.fill_data_o  (fill_data),
		.fill_done_o  (fill_done),
		.busy_o       (fetch_busy)
	);

	idct_engine engine0 (
		.Clock       (Clock),
		.Resetn      (Resetn),
		.fill_we_i   (fill_we),
		.fill_sel_i  (fill_sel),
		.fill_idx_i  (fill_idx),
		.fill_data_i (fill_data),
		.fill_done_i (fill_done),
		.in_free_o   (in_free),
		.out_valid_o (out_valid),
		.rd_idx_i    (rd_idx),
		.rd_pixel_o  (rd_pixel),
		.out_taken_i (out_taken)
	);

	block_store store0 (
		.Clock       (Clock),
		.Resetn      (Resetn),
		.cmd_push_i  (cmd_push),
		.cmd_addr_i  (out_addr_i),
		.out_valid_i (out_valid),
		.rd_idx_o    (rd_idx),
		.rd_pixel_i  (rd_pixel),
		.out_taken_o (out_taken),
		.req_o       (store_req),
		.addr_o      (store_addr),
		.wdata_o     (store_wdata),
		.gnt_i       (store_gnt),
		.done_o      (done_o)
	);

	// Fetcher reads on port a, store unit writes on port b
	sram_arbiter arb0 (
		.Clock        (Clock),
		.Resetn       (Resetn),
		.req_a_i      (fetch_req),
		.we_a_i       (1'b0),
		.addr_a_i     (fetch_addr),
		.wdata_a_i    ('0),
		.gnt_a_o      (fetch_gnt),
		.rdata_a_o    (fetch_rdata),
		.req_b_i      (store_req),
		.we_b_i       (1'b1),
		.addr_b_i     (store_addr),
		.wdata_b_i    (store_wdata),
		.gnt_b_o      (store_gnt),
		.rdata_b_o    (),
		.sram_addr_o  (sram_addr_o),
		.sram_wdata_o (sram_wdata_o),
		.sram_we_n_o  (sram_we_n_o),
		.sram_rdata_i (sram_rdata_i)
	);

endmodule

// ==== test/sram_model.sv ====
module sram_model import idct_pkg::*; (
	input  logic       Clock,
	input  sram_addr_t addr_i,
	input  sram_data_t wdata_i,
	input  logic       we_n_i,
	output sram_data_t rdata_o
);

	timeunit 1ns;
	timeprecision 100ps;

	localparam int WORDS = 1 << $bits(sram_addr_t);

	sram_data_t mem [WORDS];

	// Background pattern with the upper address bits folded in
	initial begin
		for (int a = 0; a < WORDS; a++)
			mem[a] = sram_data_t'((a * 40503) ^ (a >> 7));
	end

	always @(posedge Clock) begin
		if (!we_n_i)
			mem[addr_i] <= wdata_i;
		rdata_o <= mem[addr_i];
	end

	task automatic preload(input sram_addr_t a, input sram_data_t d);
		mem[a] = d;
	endtask

	function automatic sram_data_t peek(input sram_addr_t a);
		return mem[a];
	endfunction

endmodule

// ==== test/tb_idct_top.sv ====
`include "idct_settings.svh"

module tb_idct_top import idct_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int ISSUE_LIMIT = 2000;
	localparam int DONE_LIMIT = 6000;
	localparam real PI = 3.14159265358979;

	logic Clock;
	logic Resetn;
	logic start_i;
	sram_addr_t block_addr_i;
	sram_addr_t out_addr_i;
	logic ready_o;
	logic done_o;
	sram_addr_t sram_addr_o;
	sram_data_t sram_wdata_o;
	logic sram_we_n_o;
	sram_data_t sram_rdata_i;

	int mismatches = 0;
	int failures = 0;
	int accepted = 0;
	int done_count = 0;
	int write_count = 0;
	int coefs [64];
	sram_data_t exp_word [1 << `IDCT_SRAM_AW];
	bit exp_valid [1 << `IDCT_SRAM_AW];
	sram_addr_t exp_addrs [$];

	idct_top dut0 (
		.Clock        (Clock),
		.Resetn       (Resetn),
		.start_i      (start_i),
		.block_addr_i (block_addr_i),
		.out_addr_i   (out_addr_i),
		.ready_o      (ready_o),
		.done_o       (done_o),
		.sram_addr_o  (sram_addr_o),
		.sram_wdata_o (sram_wdata_o),
		.sram_we_n_o  (sram_we_n_o),
		.sram_rdata_i (sram_rdata_i)
	);

	sram_model sram0 (
		.Clock   (Clock),
		.addr_i  (sram_addr_o),
		.wdata_i (sram_wdata_o),
		.we_n_i  (sram_we_n_o),
		.rdata_o (sram_rdata_i)
	);

	always #4 Clock = ~Clock;

	always @(posedge Clock) begin
		if (Resetn && done_o)
			done_count <= done_count + 1;
		if (Resetn && !sram_we_n_o)
			write_count <= write_count + 1;
	end

	// Every write lands inside a destination block
	assert property (@(posedge Clock) disable iff (!Resetn)
		!sram_we_n_o |-> exp_valid[sram_addr_o])
	else begin
		failures++;
		$display("Write to address %h outside the destination blocks at %0t",
			$sampled(sram_addr_o), $time);
	end

	// Each pixel word equals the reference model
	assert property (@(posedge Clock) disable iff (!Resetn)
		(!sram_we_n_o && exp_valid[sram_addr_o]) |-> sram_wdata_o == exp_word[sram_addr_o])
	else begin
		mismatches++;
		$display("Mismatch at %0t: sram_wdata_o at address %h is %h, expected %h", $time,
			$sampled(sram_addr_o), $sampled(sram_wdata_o), exp_word[$sampled(sram_addr_o)]);
	end

	function automatic int cos_coef(input int i, input int j);
		real ci;
		ci = (i == 0) ? 1.0 / $sqrt(8.0) : 0.5;
		return int'(4096.0 * ci * $cos((2 * j + 1) * i * PI / 16.0));
	endfunction

	function automatic sram_addr_t src_addr(input int k);
		return sram_addr_t'(k * 8);
	endfunction

	function automatic sram_addr_t dst_addr(input int k);
		return sram_addr_t'(18'h20000 + k * 4);
	endfunction

	task automatic check_value(input string name, input int got, input int expected);
		assert (got == expected) else begin
			mismatches++;
			$display("Mismatch at %0t: %s is %0d, expected %0d", $time, name, got, expected);
		end
	endtask

	task automatic dc_block(input int dc);
		foreach (coefs[i])
			coefs[i] = 0;
		coefs[0] = dc;
	endtask

	// DC near mid grey and AC terms small enough for the accumulators
	task automatic random_block();
		foreach (coefs[i])
			coefs[i] = int'($urandom_range(255, 0)) - 128;
		coefs[0] = 1024 + int'($urandom_range(511, 0)) - 256;
	endtask

	// Pass one T = S' * C and pass two S = C^T * T clipped to a byte
	task automatic reference_block(input sram_addr_t out_addr);
		longint t [64];
		longint acc;
		pixel_t px [64];
		sram_addr_t a;
		for (int r = 0; r < 8; r++) begin
			for (int c = 0; c < 8; c++) begin
				acc = 0;
				for (int k = 0; k < 8; k++)
					acc += longint'(coefs[r * 8 + k]) * cos_coef(k, c);
				t[r * 8 + c] = acc >>> `IDCT_PASS1_SHIFT;
			end
		end
		for (int r = 0; r < 8; r++) begin
			for (int c = 0; c < 8; c++) begin
				acc = 0;
				for (int k = 0; k < 8; k++)
					acc += longint'(cos_coef(k, r)) * t[k * 8 + c];
				acc = acc >>> `IDCT_PASS2_SHIFT;
				px[r * 8 + c] = (acc < 0) ? 8'd0 : (acc > 255) ? 8'd255 : pixel_t'(acc);
			end
		end
		for (int r = 0; r < 8; r++) begin
			for (int w = 0; w < 4; w++) begin
				a = out_addr + sram_addr_t'(r * `IDCT_POST_STRIDE + w);
				exp_word[a] = {px[r * 8 + 2 * w], px[r * 8 + 2 * w + 1]};
				exp_valid[a] = 1'b1;
				exp_addrs.push_back(a);
			end
		end
	endtask

	task automatic prepare_block(input int k);
		for (int r = 0; r < 8; r++)
			for (int c = 0; c < 8; c++)
				sram0.preload(src_addr(k) + sram_addr_t'(r * `IDCT_PRE_STRIDE + c),
					sram_data_t'(coefs[r * 8 + c]));
		reference_block(dst_addr(k));
	endtask

	task automatic issue_command(input int k);
		int cycles;
		block_addr_i <= src_addr(k);
		out_addr_i <= dst_addr(k);
		start_i <= 1'b1;
		cycles = 0;
		do begin
			@(posedge Clock);
			cycles++;
		end while (!ready_o && cycles < ISSUE_LIMIT);
		if (ready_o)
			accepted++;
		else begin
			failures++;
			$display("Command for block %0d was not accepted within %0d cycles", k, cycles);
		end
		start_i <= 1'b0;
	endtask

	task automatic wait_for_done(input int target);
		int cycles;
		cycles = 0;
		while (done_count < target && cycles < DONE_LIMIT) begin
			@(posedge Clock);
			cycles++;
		end
		if (done_count < target) begin
			failures++;
			$display("Timed out after %0d cycles waiting for %0d finished blocks", cycles, target);
		end
	endtask

	task automatic wait_for_write();
		int cycles;
		cycles = 0;
		do begin
			@(posedge Clock);
			cycles++;
		end while (sram_we_n_o && cycles < DONE_LIMIT);
		if (sram_we_n_o) begin
			failures++;
			$display("No pixel write appeared within %0d cycles", cycles);
		end
	endtask

	task automatic check_memory();
		sram_data_t got;
		foreach (exp_addrs[i]) begin
			got = sram0.peek(exp_addrs[i]);
			assert (got === exp_word[exp_addrs[i]]) else begin
				mismatches++;
				$display("Mismatch at %0t: mem[%h] is %h, expected %h", $time, exp_addrs[i],
					got, exp_word[exp_addrs[i]]);
			end
		end
	endtask

	initial begin
		void'($urandom(37));
		Clock = 1'b0;
		Resetn = 1'b0;
		start_i = 1'b0;
		block_addr_i = '0;
		out_addr_i = '0;
		repeat (4) @(posedge Clock);
		Resetn <= 1'b1;
		@(posedge Clock);
		check_value("sram_we_n_o", sram_we_n_o, 1);
		check_value("done_o", done_o, 0);
		check_value("ready_o", ready_o, 1);

		// Single blocks in turn for DC only, random and both clipping limits
		dc_block(1000);
		prepare_block(0);
		issue_command(0);
		wait_for_done(accepted);
		random_block();
		prepare_block(1);
		issue_command(1);
		wait_for_done(accepted);
		dc_block(4000);
		prepare_block(2);
		issue_command(2);
		wait_for_done(accepted);
		dc_block(-4000);
		prepare_block(3);
		issue_command(3);
		wait_for_done(accepted);

		// Third block is fetched while the first of the pair is stored
		for (int k = 4; k < 7; k++) begin
			random_block();
			prepare_block(k);
		end
		issue_command(4);
		issue_command(5);
		wait_for_write();
		issue_command(6);
		wait_for_done(accepted);

		repeat (20) @(posedge Clock);
		check_memory();
		check_value("done pulses", done_count, accepted);
		check_value("pixel writes", write_count, 32 * accepted);

		$display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches == 0 && failures == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

// ==== idct_block.f ====
+incdir+source
source/idct_pkg.sv
source/coeff_rom.sv
source/sram_arbiter.sv
source/block_fetch.sv
source/idct_engine.sv
source/block_store.sv
source/idct_top.sv
test/sram_model.sv
test/tb_idct_top.sv

// ==== Bender.yml ====
package:
  name: idct_block

sources:
  - include_dirs:
      - source
    files:
      - source/idct_pkg.sv
      - source/coeff_rom.sv
      - source/sram_arbiter.sv
      - source/block_fetch.sv
      - source/idct_engine.sv
      - source/block_store.sv
      - source/idct_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - test/sram_model.sv
      - test/tb_idct_top.sv
